// ==== Makefile ====
TOP = muscle_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// ==== all.f ====
rtl/muscle_pkg.sv
rtl/twitch_filter.sv
rtl/length_weight.sv
rtl/tension_integrator.sv
rtl/muscle_top.sv
tests/muscle_tb.sv

// ==== rtl/length_weight.sv ====
module length_weight (
    input  muscle_pkg::fx_t pos_i,
    input  muscle_pkg::fx_t active_i,
    output muscle_pkg::fx_t activation_o
);

    import muscle_pkg::*;

    ////////////////////////////////////////////////////////////
    // force-length curve
    ////////////////////////////////////////////////////////////

    // shared square of the length
    fx_t pos_sq;
    // long branch, -x^2 + 2x
    fx_t w_long;
    // short branch, -4x^2 + 8x - 3 written as 4*(2x - x^2) - 3
    fx_t w_short;
    fx_t weight;

    assign pos_sq  = fx_mul(pos_i, pos_i);
    assign w_long  = fx_sat_sub(fx_mul(FX_TWO, pos_i), pos_sq);
    assign w_short = fx_sat_sub(fx_mul(FX_FOUR, w_long), FX_THREE);

    // both branches peak at 1.0 for rest length,
    // zero force outside 0.5 .. 2.0
    always_comb begin
        if (pos_i <= FX_HALF) begin
            weight = '0;
        end else if (pos_i <= FX_ONE) begin
            weight = w_short;
        end else if (pos_i <= FX_TWO) begin
            weight = w_long;
        end else begin
            weight = '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // activation
    ////////////////////////////////////////////////////////////

    // active state scaled by how well filaments overlap
    assign activation_o = fx_mul(weight, active_i);

endmodule

// ==== rtl/muscle_pkg.sv ====
package muscle_pkg;

    ////////////////////////////////////////////////////////////
    // number format
    ////////////////////////////////////////////////////////////

    // signed q16.16 with 16 integer bits incl. sign and 16 fraction bits
    typedef logic signed [31:0] fx_t;

    localparam int FX_FRAC_W = 16;

    localparam fx_t FX_MAX   = 32'sh7fff_ffff;
    localparam fx_t FX_MIN   = 32'sh8000_0000;
    localparam fx_t FX_HALF  = 32'sh0000_8000;
    localparam fx_t FX_ONE   = 32'sh0001_0000;
    localparam fx_t FX_TWO   = 32'sh0002_0000;
    localparam fx_t FX_THREE = 32'sh0003_0000;
    localparam fx_t FX_FOUR  = 32'sh0004_0000;

    ////////////////////////////////////////////////////////////
    // muscle tension model constants
    ////////////////////////////////////////////////////////////

    // muscle rest length
    localparam fx_t REST_LENGTH = FX_ONE;
    // kse*kpe/b = 204.0
    localparam fx_t K_STRETCH = 32'sd13369344;
    // kse = 136.0 multiplies lengthening velocity
    localparam fx_t K_VEL = 32'sd8912896;
    // kse/b*(1+kpe/kse) = 4.22 rounded to nearest q16.16
    localparam fx_t K_TENSION = 32'sd276562;
    // kse/b = 2.72 rounded to nearest q16.16
    localparam fx_t K_ACT = 32'sd178258;
    // euler step of 2^-10 s is close to one millisecond
    localparam int DT_SHIFT = 10;

    ////////////////////////////////////////////////////////////
    // twitch coefficient sets
    ////////////////////////////////////////////////////////////

    localparam int TAU_SEL_W = 2;
    localparam int TAU_SEL_CNT = 1 << TAU_SEL_W;

    // a = exp(-T/tau) with T = 1 ms
    // index 0..3 is tau = 25, 40, 60, 100 ms
    // b1 = e*T*a/tau
    localparam fx_t TWITCH_B1 [0:TAU_SEL_CNT-1] = '{
        32'sd6846, 32'sd4344, 32'sd2920, 32'sd1764
    };
    // a1 = -2a
    localparam fx_t TWITCH_A1 [0:TAU_SEL_CNT-1] = '{
        -32'sd125933, -32'sd127836, -32'sd128906, -32'sd129768
    };
    // a2 = a^2
    localparam fx_t TWITCH_A2 [0:TAU_SEL_CNT-1] = '{
        32'sd60497, 32'sd62340, 32'sd63387, 32'sd64238
    };

    ////////////////////////////////////////////////////////////
    // saturating arithmetic
    ////////////////////////////////////////////////////////////

    // clamp a wide intermediate into the 32-bit signed range
    function automatic fx_t fx_sat64(input logic signed [63:0] v);
        if (v > FX_MAX) begin
            return FX_MAX;
        end else if (v < FX_MIN) begin
            return FX_MIN;
        end
        return fx_t'(v[31:0]);
    endfunction

    // full product then floor shift back to q16.16 and clamp
    function automatic fx_t fx_mul(input fx_t a, input fx_t b);
        logic signed [63:0] prod;
        prod = a * b;
        return fx_sat64(prod >>> FX_FRAC_W);
    endfunction

    // 33-bit sum overflows when the top two bits differ
    function automatic fx_t fx_sat_add(input fx_t a, input fx_t b);
        logic signed [32:0] sum;
        sum = a + b;
        if (sum[32] != sum[31]) begin
            return sum[32] ? FX_MIN : FX_MAX;
        end
        return fx_t'(sum[31:0]);
    endfunction

    function automatic fx_t fx_sat_sub(input fx_t a, input fx_t b);
        logic signed [32:0] diff;
        diff = a - b;
        if (diff[32] != diff[31]) begin
            return diff[32] ? FX_MIN : FX_MAX;
        end
        return fx_t'(diff[31:0]);
    endfunction

endpackage

// ==== rtl/muscle_top.sv ====
module muscle_top (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [31:0]                      spike_cnt_i,
    input  muscle_pkg::fx_t                  pos_i,
    input  muscle_pkg::fx_t                  vel_i,
    input  logic [muscle_pkg::TAU_SEL_W-1:0] tau_sel_i,
    output muscle_pkg::fx_t                  active_o,
    output muscle_pkg::fx_t                  activation_o,
    output muscle_pkg::fx_t                  force_o
);

    import muscle_pkg::*;

    // active state h1 and weighted activation
    fx_t active;
    fx_t activation;

    // spike train to active state
    twitch_filter u_twitch_filter (
        .clk         (clk),
        .reset       (reset),
        .spike_cnt_i (spike_cnt_i),
        .tau_sel_i   (tau_sel_i),
        .active_o    (active)
    );

    // length dependent scaling
    length_weight u_length_weight (
        .pos_i        (pos_i),
        .active_i     (active),
        .activation_o (activation)
    );

    // activation, length and velocity to force
    tension_integrator u_tension_integrator (
        .clk          (clk),
        .reset        (reset),
        .pos_i        (pos_i),
        .vel_i        (vel_i),
        .activation_i (activation),
        .force_o      (force_o)
    );

    assign active_o     = active;
    assign activation_o = activation;

    // force-length weight stays inside 0 .. 1.0 for every length
    a_weight_range : assert property (
        @(posedge clk) disable iff (reset)
        (u_length_weight.weight >= 0) && (u_length_weight.weight <= FX_ONE)
    ) else $error("muscle_top: length weight out of range");

endmodule

// ==== rtl/tension_integrator.sv ====
module tension_integrator (
    input  logic            clk,
    input  logic            reset,
    input  muscle_pkg::fx_t pos_i,
    input  muscle_pkg::fx_t vel_i,
    input  muscle_pkg::fx_t activation_i,
    output muscle_pkg::fx_t force_o
);

    import muscle_pkg::*;

    ////////////////////////////////////////////////////////////
    // tension derivative
    ////////////////////////////////////////////////////////////

    // registered derivative and integrated tension
    fx_t dt_q;
    fx_t t_q;

    fx_t stretch;
    fx_t passive;
    fx_t damping;
    fx_t decay;
    fx_t drive;
    fx_t sum_pv;
    fx_t sum_pvd;
    fx_t dt_next;
    fx_t t_next;

    // parallel element only pulls when stretched beyond rest
    assign stretch = fx_sat_sub(pos_i, REST_LENGTH);
    assign passive = (pos_i < REST_LENGTH) ? '0 : fx_mul(K_STRETCH, stretch);

    // series spring loaded by lengthening velocity
    assign damping = fx_mul(K_VEL, vel_i);
    // tension relaxes in proportion to itself
    assign decay = fx_mul(K_TENSION, t_q);
    // contractile drive
    assign drive = fx_mul(K_ACT, activation_i);

    // summed left to right with each step saturating
    assign sum_pv  = fx_sat_add(passive, damping);
    assign sum_pvd = fx_sat_sub(sum_pv, decay);
    assign dt_next = fx_sat_add(sum_pvd, drive);

    ////////////////////////////////////////////////////////////
    // euler step
    ////////////////////////////////////////////////////////////

    // step size 2^-DT_SHIFT as a floor shift of the stored derivative
    assign t_next = fx_sat_add(t_q, dt_q >>> DT_SHIFT);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dt_q <= '0;
            t_q  <= '0;
        end else begin
            dt_q <= dt_next;
            t_q  <= t_next;
        end
    end

    assign force_o = t_q;

endmodule

// ==== rtl/twitch_filter.sv ====
module twitch_filter (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [31:0]                      spike_cnt_i,
    input  logic [muscle_pkg::TAU_SEL_W-1:0] tau_sel_i,
    output muscle_pkg::fx_t                  active_o
);

    import muscle_pkg::*;

    ////////////////////////////////////////////////////////////
    // spike count to q16.16
    ////////////////////////////////////////////////////////////

    fx_t x_in;

    // counts of 32768 and above do not fit and clamp to the top
    assign x_in = (|spike_cnt_i[31:15]) ? FX_MAX
                                        : fx_t'({1'b0, spike_cnt_i[14:0], 16'h0000});

    ////////////////////////////////////////////////////////////
    // twitch difference equation
    ////////////////////////////////////////////////////////////

    // input history and state history
    fx_t x1;
    fx_t h1;
    fx_t h2;

    fx_t b1;
    fx_t a1;
    fx_t a2;
    fx_t h;

    // coefficient set picked by contraction time
    assign b1 = TWITCH_B1[tau_sel_i];
    assign a1 = TWITCH_A1[tau_sel_i];
    assign a2 = TWITCH_A2[tau_sel_i];

    // h = b1*x1 - a1*h1 - a2*h2
    // the b2 tap on the older input is zero and left out
    assign h = fx_sat_sub(fx_sat_sub(fx_mul(b1, x1), fx_mul(a1, h1)), fx_mul(a2, h2));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            x1 <= '0;
            h1 <= '0;
            h2 <= '0;
        end else begin
            // advance input and state history by one sample
            x1 <= x_in;
            h1 <= h;
            h2 <= h1;
        end
    end

    assign active_o = h1;

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // output is fully defined once out of reset
    a_active_known : assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(active_o)
    ) else $error("twitch_filter: active_o has unknown bits");

endmodule

// ==== tests/muscle_tb.sv ====
module muscle_tb;

    timeunit 1ns;
    timeprecision 1ps;

    typedef logic signed [31:0] q_t;

    // q16.16 reference constants
    localparam q_t Q_MAX = 32'sh7fff_ffff;
    localparam q_t Q_MIN = 32'sh8000_0000;
    localparam q_t Q_HALF = 32'sh0000_8000;
    localparam q_t Q_ONE = 32'sh0001_0000;
    localparam q_t Q_TWO = 32'sh0002_0000;
    localparam q_t K_STRETCH = 32'sd13369344;
    localparam q_t K_VEL = 32'sd8912896;
    localparam q_t K_TENSION = 32'sd276562;
    localparam q_t K_ACT = 32'sd178258;
    // twitch sets for tau = 25, 40, 60, 100 ms
    localparam q_t COEF_B1 [0:3] = '{32'sd6846, 32'sd4344, 32'sd2920, 32'sd1764};
    localparam q_t COEF_A1 [0:3] = '{-32'sd125933, -32'sd127836, -32'sd128906, -32'sd129768};
    localparam q_t COEF_A2 [0:3] = '{32'sd60497, 32'sd62340, 32'sd63387, 32'sd64238};
    // 0.4, 0.75, 1.0, 1.5, 2.5
    localparam q_t SWEEP [0:4] = '{32'sd26214, 32'sd49152, 32'sd65536, 32'sd98304, 32'sd163840};

    logic clk;
    logic reset;
    logic [31:0] spike_cnt_i;
    q_t pos_i;
    q_t vel_i;
    logic [1:0] tau_sel_i;
    q_t active_o;
    q_t activation_o;
    q_t force_o;

    // software copy of the DUT registers
    q_t m_x1;
    q_t m_h1;
    q_t m_h2;
    q_t m_dt;
    q_t m_t;
    q_t tail [0:3];
    int mismatch_cnt = 0;
    int check_cnt = 0;
    int timeout_cnt = 0;

    muscle_top UUT (
        .clk          (clk),
        .reset        (reset),
        .spike_cnt_i  (spike_cnt_i),
        .pos_i        (pos_i),
        .vel_i        (vel_i),
        .tau_sel_i    (tau_sel_i),
        .active_o     (active_o),
        .activation_o (activation_o),
        .force_o      (force_o)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic q_t clamp32(input longint v);
        if (v > longint'(Q_MAX)) return Q_MAX;
        if (v < longint'(Q_MIN)) return Q_MIN;
        return q_t'(v);
    endfunction

    // floor of the full product
    function automatic q_t mul_fix(input q_t a, input q_t b);
        return clamp32((longint'(a) * longint'(b)) >>> 16);
    endfunction

    function automatic q_t add_sat(input q_t a, input q_t b);
        return clamp32(longint'(a) + longint'(b));
    endfunction

    function automatic q_t sub_sat(input q_t a, input q_t b);
        return clamp32(longint'(a) - longint'(b));
    endfunction

    function automatic q_t spike_to_fix(input logic [31:0] c);
        if (c > 32'd32767) return Q_MAX;
        return q_t'(c << 16);
    endfunction

    // force-length weight is zero outside 0.5 .. 2.0
    function automatic q_t weight_of(input q_t p);
        q_t sq;
        sq = mul_fix(p, p);
        if (p <= Q_HALF || p > Q_TWO) return 32'sd0;
        if (p <= Q_ONE) begin
            return sub_sat(sub_sat(mul_fix(32'sh0008_0000, p), mul_fix(32'sh0004_0000, sq)),
                           32'sh0003_0000);
        end
        return sub_sat(mul_fix(Q_TWO, p), sq);
    endfunction

    // one clock of the whole muscle from the inputs seen at the edge
    function automatic void step_model(input logic [31:0] spike, input q_t pos, input q_t vel,
                                       input logic [1:0] tau);
        q_t h;
        q_t act;
        q_t passive;
        q_t deriv;
        h = sub_sat(sub_sat(mul_fix(COEF_B1[tau], m_x1), mul_fix(COEF_A1[tau], m_h1)),
                    mul_fix(COEF_A2[tau], m_h2));
        act = mul_fix(weight_of(pos), m_h1);
        // passive spring clipped below rest length
        passive = (pos < Q_ONE) ? 32'sd0 : mul_fix(K_STRETCH, sub_sat(pos, Q_ONE));
        deriv = add_sat(sub_sat(add_sat(passive, mul_fix(K_VEL, vel)), mul_fix(K_TENSION, m_t)),
                        mul_fix(K_ACT, act));
        m_t = add_sat(m_t, m_dt >>> 10);
        m_dt = deriv;
        m_h2 = m_h1;
        m_h1 = h;
        m_x1 = spike_to_fix(spike);
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            m_x1 = '0;
            m_h1 = '0;
            m_h2 = '0;
            m_dt = '0;
            m_t = '0;
        end else begin
            step_model(spike_cnt_i, pos_i, vel_i, tau_sel_i);
        end
    end

    task automatic report_value(input string name, input longint exp_v, input longint got_v);
        $display("error at %0t: %s expected %0d got %0d", $time, name, exp_v, got_v);
    endtask

    // compare on the falling edge where outputs have settled
    always @(negedge clk) begin
        q_t exp_activation;
        if (!reset) begin
            exp_activation = mul_fix(weight_of(pos_i), m_h1);
            if (active_o != m_h1) begin
                mismatch_cnt++;
                report_value("active_o", m_h1, active_o);
            end
            if (activation_o != exp_activation) begin
                mismatch_cnt++;
                report_value("activation_o", exp_activation, activation_o);
            end
            if (force_o != m_t) begin
                mismatch_cnt++;
                report_value("force_o", m_t, force_o);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    // idle inputs at rest length during a 10 cycle reset
    task automatic apply_reset(input logic [1:0] tau);
        @(posedge clk);
        reset <= 1'b1;
        spike_cnt_i <= '0;
        pos_i <= Q_ONE;
        vel_i <= '0;
        tau_sel_i <= tau;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
    endtask

    initial begin
        int n;
        q_t prev;
        void'($urandom(32'h4c28_7e2e));
        clk = 1'b0;
        reset = 1'b1;
        spike_cnt_i = '0;
        pos_i = Q_ONE;
        vel_i = '0;
        tau_sel_i = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // quiet muscle at rest length
        for (n = 0; n < 50; n++) begin
            @(negedge clk);
            if (active_o != 0) begin
                check_cnt++;
                report_value("active_o", 0, active_o);
            end
            if (activation_o != 0) begin
                check_cnt++;
                report_value("activation_o", 0, activation_o);
            end
            if (force_o != 0) begin
                check_cnt++;
                report_value("force_o", 0, force_o);
            end
        end

        // single twitch per contraction time
        for (int sel = 0; sel < 4; sel++) begin
            apply_reset(2'(sel));
            @(posedge clk);
            spike_cnt_i <= 32'd1;
            @(posedge clk);
            spike_cnt_i <= 32'd0;
            n = 1;
            @(negedge clk);
            while (active_o == 0 && n < 10) begin
                @(negedge clk);
                n++;
            end
            if (active_o == 0) begin
                timeout_cnt++;
                $display("timeout waiting for the twitch rise with tau_sel %0d", sel);
            end else if (n != 2) begin
                check_cnt++;
                report_value("twitch latency", 2, n);
            end
            while (n < 150) begin
                @(negedge clk);
                n++;
            end
            // slower twitches keep more of their peak
            tail[sel] = active_o;
            if (sel > 0 && tail[sel] <= tail[sel-1]) begin
                check_cnt++;
                $display("twitch with tau_sel %0d decays no slower than the one before", sel);
            end
        end

        // length sweep under a steady spike train
        apply_reset(2'd0);
        @(posedge clk);
        spike_cnt_i <= 32'd2;
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            pos_i <= SWEEP[i];
            repeat (60) @(negedge clk);
            if (active_o == 0) begin
                check_cnt++;
                $display("active state stayed zero in the length sweep");
            end else if (SWEEP[i] <= Q_HALF || SWEEP[i] > Q_TWO) begin
                if (activation_o != 0) begin
                    check_cnt++;
                    report_value("activation_o", 0, activation_o);
                end
            end else if (SWEEP[i] == Q_ONE) begin
                // full overlap at rest length gives a weight of exactly one
                if (activation_o != active_o) begin
                    check_cnt++;
                    report_value("activation_o", active_o, activation_o);
                end
            end else if (activation_o <= 0) begin
                check_cnt++;
                $display("activation stayed at or below zero inside the working range");
            end
        end

        // passive stretch at 1.2 raises force monotonically
        apply_reset(2'd0);
        @(posedge clk);
        pos_i <= 32'sd78643;
        prev = '0;
        n = 0;
        while (force_o < Q_ONE && n < 1000) begin
            @(negedge clk);
            if (force_o < prev) begin
                check_cnt++;
                report_value("force_o", prev, force_o);
            end
            prev = force_o;
            n++;
        end
        if (force_o < Q_ONE) begin
            timeout_cnt++;
            $display("timeout waiting for passive force to build up");
        end

        // shortened to 0.9 the passive branch is clipped
        apply_reset(2'd0);
        @(posedge clk);
        pos_i <= 32'sd58982;
        repeat (100) begin
            @(negedge clk);
            if (force_o != 0) begin
                check_cnt++;
                report_value("force_o", 0, force_o);
            end
        end

        // random traffic checked every cycle by the compare process
        apply_reset(2'd0);
        repeat (2000) begin
            @(posedge clk);
            spike_cnt_i <= $urandom_range(15, 0);
            pos_i <= $signed($urandom_range(144179, 26214));
            vel_i <= $signed($urandom_range(6554, 0)) - 32'sd3277;
            tau_sel_i <= 2'($urandom_range(3, 0));
        end

        // heavy drive plus fast lengthening pins force at the top
        apply_reset(2'd0);
        @(posedge clk);
        spike_cnt_i <= 32'd160;
        vel_i <= 32'sd19660800;
        n = 0;
        while (force_o != Q_MAX && n < 5000) begin
            @(negedge clk);
            n++;
        end
        if (force_o != Q_MAX) begin
            timeout_cnt++;
            $display("timeout waiting for force to saturate");
        end
        repeat (20) @(negedge clk);
        if (force_o != Q_MAX) begin
            check_cnt++;
            report_value("force_o", Q_MAX, force_o);
        end

        $display("summary: %0d mismatches, %0d failed checks, %0d timeouts",
                 mismatch_cnt, check_cnt, timeout_cnt);
        if (mismatch_cnt == 0 && check_cnt == 0 && timeout_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
